//--- Makefile
VERILATOR ?= verilator
TOP       ?= mips_cpu_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
hw/mips_pkg.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_pc.sv
hw/mips_fsm.sv
hw/mips_cpu.sv
verif/avalon_ram.sv
verif/mips_cpu_tb.sv

//--- hw/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    output logic [31:0]       y
);
    import mips_pkg::*;

    logic lt;   // signed a < b

    assign lt = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            alu_add: y = a + b;                         // wraps, no overflow trap
            alu_slt: y = {{(word_w-1){1'b0}}, lt};
            alu_sll: y = b << shamt;                    // rt shifted, rs ignored
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic [31:0] writedata,
    output logic        write,
    output logic        read,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);
    import mips_pkg::*;

    logic [word_w-1:0] ir;
    logic [word_w-1:0] mdr;
    logic [word_w-1:0] alu_res;
    logic [word_w-1:0] alu_y;
    logic [word_w-1:0] pc;
    logic [word_w-1:0] rda;
    logic [word_w-1:0] rdb;
    logic [word_w-1:0] imm_ext;
    logic [word_w-1:0] alu_b;
    logic [word_w-1:0] rf_wd;
    logic [5:0]        opcode;
    logic [5:0]        funct;
    logic [4:0]        rs;
    logic [4:0]        rt;
    logic [4:0]        rd;
    logic [4:0]        shamt;
    logic [4:0]        rf_wa;
    logic              ir_load;
    logic              pc_inc;
    logic              pc_load;
    logic              rf_we;
    logic              mdr_load;
    logic              jump_zero;
    logic              is_rtype;
    logic              is_mem;
    logic              data_phase; // between fetch and the data transfer
    alu_op_t           alu_op;

    assign opcode  = ir[31:26];
    assign rs      = ir[25:21];
    assign rt      = ir[20:16];
    assign rd      = ir[15:11];
    assign shamt   = ir[10:6];
    assign funct   = ir[5:0];
    assign imm_ext = {{16{ir[15]}}, ir[15:0]};

    assign is_rtype  = (opcode == op_rtype);
    assign is_mem    = (opcode == op_lw) || (opcode == op_sw);
    assign alu_b     = is_rtype ? rdb : imm_ext;
    assign rf_wa     = is_rtype ? rd : rt;
    assign rf_wd     = (opcode == op_lw) ? mdr : alu_res;
    assign jump_zero = (rda == '0);    // jr $0 halts

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir         <= '0;          // decodes as a nop
            data_phase <= 1'b0;
        end else begin
            if (ir_load) begin
                ir <= readdata;
            end
            if (ir_load) begin
                data_phase <= 1'b1;
            end else if ((read || write) && !waitrequest) begin
                data_phase <= 1'b0;
            end
        end
    end

    // operands hold from decode to wb, so the result is steady through mem
    always_ff @(posedge clk) begin
        if (mdr_load) begin
            mdr <= readdata;
        end
        alu_res <= alu_y;
    end

    assign address   = (data_phase && is_mem) ? alu_res : pc;
    assign writedata = rdb;

    mips_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .funct       (funct),
        .jump_zero   (jump_zero),
        .waitrequest (waitrequest),
        .read        (read),
        .write       (write),
        .ir_load     (ir_load),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .rf_we       (rf_we),
        .mdr_load    (mdr_load),
        .active      (active),
        .alu_op      (alu_op)
    );

    mips_pc u_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_inc      (pc_inc),
        .pc_load     (pc_load),
        .jump_target (rda),
        .pc          (pc)
    );

    mips_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (rf_we),
        .ra    (rs),
        .rb    (rt),
        .wa    (rf_wa),
        .wd    (rf_wd),
        .rda   (rda),
        .rdb   (rdb),
        .v0    (register_v0)
    );

    mips_alu u_alu (
        .op    (alu_op),
        .a     (rda),
        .b     (alu_b),
        .shamt (shamt),
        .y     (alu_y)
    );

    // a stalled transfer keeps its address and data
    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (read || write) && waitrequest |=>
            $stable(address) && $stable(writedata) && $stable(read) && $stable(write));

endmodule

`default_nettype wire

//--- hw/mips_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module mips_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [5:0]        opcode,
    input  logic [5:0]        funct,
    input  logic              jump_zero,
    input  logic              waitrequest,
    output logic              read,
    output logic              write,
    output logic              ir_load,
    output logic              pc_inc,
    output logic              pc_load,
    output logic              rf_we,
    output logic              mdr_load,
    output logic              active,
    output mips_pkg::alu_op_t alu_op
);
    import mips_pkg::*;

    fsm_state_t state;
    fsm_state_t state_nxt;
    logic       run;        // set on the first edge after reset
    logic       is_jr;
    logic       is_lw;
    logic       is_sw;
    logic       writes_reg;

    assign is_jr      = (opcode == op_rtype) && (funct == fn_jr);
    assign is_lw      = (opcode == op_lw);
    assign is_sw      = (opcode == op_sw);
    assign writes_reg = ((opcode == op_rtype) && (funct == fn_addu || funct == fn_sll)) ||
                        (opcode == op_addiu) || (opcode == op_slti) || is_lw;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_fetch;
            run   <= 1'b0;
        end else begin
            state <= state_nxt;
            run   <= 1'b1;
        end
    end

    assign active   = run && (state != st_halt);
    assign read     = active && ((state == st_fetch) || ((state == st_mem) && is_lw));
    assign write    = active && (state == st_mem) && is_sw;
    assign ir_load  = (state == st_fetch) && read && !waitrequest; // fetch completes
    assign pc_inc   = ir_load;
    assign pc_load  = (state == st_exec) && is_jr && !jump_zero;
    assign mdr_load = (state == st_mem) && read && !waitrequest;
    assign rf_we    = (state == st_wb);

    always_comb begin
        state_nxt = state;
        case (state)
            st_fetch:  if (ir_load) state_nxt = st_decode;
            st_decode: state_nxt = st_exec;
            st_exec: begin
                if (is_jr) begin
                    state_nxt = jump_zero ? st_halt : st_fetch;
                end else if (is_lw || is_sw) begin
                    state_nxt = st_mem;
                end else if (writes_reg) begin
                    state_nxt = st_wb;
                end else begin
                    state_nxt = st_fetch;   // unknown op runs as a nop
                end
            end
            st_mem:    if (!waitrequest) state_nxt = is_lw ? st_wb : st_fetch;
            st_wb:     state_nxt = st_fetch;
            st_halt:   state_nxt = st_halt;
            default:   state_nxt = st_fetch;
        endcase
    end

    always_comb begin
        if (opcode == op_slti) begin
            alu_op = alu_slt;
        end else if (opcode == op_rtype && funct == fn_sll) begin
            alu_op = alu_sll;
        end else begin
            alu_op = alu_add;   // addu, addiu and load/store address
        end
    end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(read && write));

    // halting is final and the core stays off the bus
    a_halt_final: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_halt) |=> (state == st_halt) && !active);

endmodule

`default_nettype wire

//--- hw/mips_pc.sv
`timescale 1ns/1ps
`default_nettype none

module mips_pc (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pc_inc,
    input  logic        pc_load,
    input  logic [31:0] jump_target,
    output logic [31:0] pc
);
    import mips_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_vector;
        end else if (pc_load) begin
            pc <= jump_target;      // jr, no delay slot
        end else if (pc_inc) begin
            pc <= pc + 32'd4;
        end
    end

    // jr targets come straight from the register file
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int word_w = 32;                                // data and address width
    localparam logic [word_w-1:0] reset_vector = 32'h0000_0004; // first fetch address

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // function codes for op_rtype
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_jr    = 6'h08;
    localparam logic [5:0] fn_addu  = 6'h21;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_slt = 2'd1,
        alu_sll = 2'd2
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch  = 3'd0,
        st_decode = 3'd1,
        st_exec   = 3'd2,
        st_mem    = 3'd3,
        st_wb     = 3'd4,
        st_halt   = 3'd5
    } fsm_state_t;

    localparam logic [4:0] reg_v0 = 5'd2; // debug view register

endpackage

`default_nettype wire

//--- hw/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        we,
    input  logic [4:0]  ra,
    input  logic [4:0]  rb,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rda,
    output logic [31:0] rdb,
    output logic [31:0] v0
);
    import mips_pkg::*;

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;         // $0 never written, so it reads zero
        end
    end

    assign rda = regs[ra];
    assign rdb = regs[rb];
    assign v0  = regs[reg_v0];     // debug port

endmodule

`default_nettype wire

//--- verif/avalon_ram.sv
`timescale 1ns/1ps
`default_nettype none

module avalon_ram #(
    parameter int depth = 64                // words
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_data
);
    localparam int idx_w = $clog2(depth);

    logic [31:0]      mem [depth];
    logic [idx_w-1:0] idx;
    logic [1:0]       stall_left;   // cycles before the open transfer completes

    assign idx         = address[idx_w+1:2];
    assign readdata    = mem[idx];  // valid in the completing cycle
    assign waitrequest = (read || write) && (stall_left != 2'd0);

    // stalls for the next transfer are drawn as the current one completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_left <= 2'd0;
        end else if (read || write) begin
            if (stall_left == 2'd0) begin
                stall_left <= 2'($urandom_range(0, 3));
            end else begin
                stall_left <= stall_left - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[idx_w+1:2]] <= load_data;   // program load
        end else if (write && !waitrequest) begin
            mem[idx] <= writedata;
        end
    end

endmodule

`default_nettype wire

//--- verif/mips_cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb;
    import mips_pkg::*;

    localparam int          prog_len       = 41;    // 40 random instructions and jr $0
    localparam int          ram_words      = 64;    // byte addresses 0x00 to 0xff
    localparam logic [31:0] data_base      = 32'h0000_00c0;
    localparam int          timeout_cycles = prog_len * 12 + 100;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] writedata;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;

    logic [31:0] prog [prog_len];
    logic [31:0] model_mem [ram_words];
    logic [31:0] model_regs [32];
    logic [31:0] model_v0;
    logic        exp_write_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] exp_data_q [$];

    int          errors;
    int          checks;
    int          run_cycles;
    int unsigned seed_ret;
    logic        running;
    logic        first_read_seen;
    logic        prev_stall;
    logic        prev_read;
    logic        prev_write;
    logic [31:0] prev_address;
    logic [31:0] prev_writedata;

    mips_cpu uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .writedata   (writedata),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    avalon_ram #(.depth(ram_words)) u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] sh,
                                          input logic [5:0] fn);
        return {op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // background contents, a hash of the byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5ac3_0f96;
    endfunction

    task automatic make_random_program();
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] offs;
        int unsigned kind;
        int          i;
        for (i = 0; i < prog_len - 1; i++) begin
            kind = $urandom_range(0, 5);
            ra   = 5'($urandom_range(1, 7));
            rb   = 5'($urandom_range(1, 7));
            rd   = 5'($urandom_range(1, 7));
            imm  = 16'($urandom);
            offs = data_base[15:0] + {10'd0, imm[3:0], 2'b00};  // one of 16 data words
            case (kind)
                0:       prog[i] = enc_i(op_addiu, ra, rd, imm);
                1:       prog[i] = enc_i(op_slti, ra, rd, imm);
                2:       prog[i] = enc_r(5'd0, rb, rd, imm[4:0], fn_sll);
                3:       prog[i] = enc_r(ra, rb, rd, 5'd0, fn_addu);
                4:       prog[i] = enc_i(op_sw, 5'd0, rb, offs);
                default: prog[i] = enc_i(op_lw, 5'd0, rd, offs);
            endcase
        end
        prog[prog_len-1] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_jr);
    endtask

    // signed compare of 0xffff0000 against 0xfffff00f lands in v0
    task automatic make_slti_program();
        prog    = '{default: '0};
        prog[0] = enc_i(op_addiu, 5'd0, 5'd3, 16'hffff);
        prog[1] = enc_r(5'd0, 5'd3, 5'd3, 5'd16, fn_sll);
        prog[2] = enc_i(op_slti, 5'd3, reg_v0, 16'hf00f);
        prog[3] = enc_i(op_addiu, 5'd0, 5'd4, 16'hf00f);
        prog[4] = enc_i(op_slti, 5'd4, 5'd5, 16'hf000);
        prog[5] = enc_i(op_sw, 5'd0, 5'd5, data_base[15:0]);
        prog[6] = enc_i(op_sw, 5'd0, reg_v0, data_base[15:0] + 16'd4);
        prog[7] = enc_r(5'd0, 5'd0, 5'd0, 5'd0, fn_jr);
    endtask

    task automatic load_ram();
        int i;
        for (i = 0; i < ram_words; i++) begin
            model_mem[i] = fill_word(32'(i) << 2);
            if (i >= 1 && i <= prog_len) begin
                model_mem[i] = prog[i-1];   // program starts at 0x4
            end
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 32'(i) << 2;
            load_data <= model_mem[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic expect_transfer(input logic is_write, input logic [31:0] addr,
                                   input logic [31:0] data);
        exp_write_q.push_back(is_write);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endtask

    // instruction-set model, sequential and without a delay slot
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_ext;
        logic [31:0] ea;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic        lt;
        logic        halted;
        int          steps;
        model_regs = '{default: '0};
        exp_write_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        pc     = reset_vector;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < 200) begin
            ins = model_mem[pc[7:2]];
            expect_transfer(1'b0, pc, ins);
            rt      = ins[20:16];
            rd      = ins[15:11];
            a       = model_regs[ins[25:21]];
            b       = model_regs[rt];
            imm_ext = {{16{ins[15]}}, ins[15:0]};
            ea      = a + imm_ext;
            lt      = $signed(a) < $signed(imm_ext);
            pc      = pc + 32'd4;
            case (ins[31:26])
                op_rtype: begin
                    if (ins[5:0] == fn_jr) begin
                        if (a == 32'd0) begin
                            halted = 1'b1;
                        end else begin
                            pc = a;
                        end
                    end else if (ins[5:0] == fn_addu) begin
                        model_regs[rd] = a + b;
                    end else if (ins[5:0] == fn_sll) begin
                        model_regs[rd] = b << ins[10:6];
                    end
                end
                op_addiu: model_regs[rt] = ea;
                op_slti:  model_regs[rt] = {31'd0, lt};
                op_lw: begin
                    expect_transfer(1'b0, ea, model_mem[ea[7:2]]);
                    model_regs[rt] = model_mem[ea[7:2]];
                end
                op_sw: begin
                    expect_transfer(1'b1, ea, b);
                    model_mem[ea[7:2]] = b;
                end
                default: ;
            endcase
            model_regs[0] = 32'd0;
            steps++;
        end
        model_v0 = model_regs[2];
    endtask

    task automatic run_program();
        logic seen_active;
        int   i;
        load_ram();
        run_model();
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n   <= 1'b1;
        running <= 1'b1;
        seen_active = 1'b0;
        while (!(seen_active && !active)) begin
            @(negedge clk);
            if (active) begin
                seen_active = 1'b1;
            end
        end
        running <= 1'b0;
        check_value("register_v0", register_v0, model_v0);
        for (i = 0; i < 20; i++) begin
            @(negedge clk);
            check_value("active after halt", 32'(active), 32'd0);
            check_value("read after halt", 32'(read), 32'd0);
            check_value("write after halt", 32'(write), 32'd0);
        end
        check_value("transfers left", 32'(exp_addr_q.size()), 32'd0);
    endtask

    // bus monitor, sampled on the falling edge where everything is settled
    always @(negedge clk) begin
        if (!rst_n) begin
            prev_stall      = 1'b0;
            first_read_seen = 1'b0;
        end else begin
            if (prev_stall) begin
                check_value("address in stall", address, prev_address);
                check_value("read in stall", 32'(read), 32'(prev_read));
                check_value("write in stall", 32'(write), 32'(prev_write));
                check_value("writedata in stall", writedata, prev_writedata);
            end
            if (read && !first_read_seen) begin
                check_value("first fetch address", address, 32'h0000_0004);
                first_read_seen = 1'b1;
            end
            if ((read || write) && !waitrequest) begin
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("Error at time %0t: bus transfer to %h after the model halted",
                             $time, address);
                end else begin
                    check_value("write", 32'(write), 32'(exp_write_q[0]));
                    check_value("address", address, exp_addr_q[0]);
                    if (write) begin
                        check_value("writedata", writedata, exp_data_q[0]);
                    end
                    void'(exp_write_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
            end
            prev_stall     = (read || write) && waitrequest;
            prev_read      = read;
            prev_write     = write;
            prev_address   = address;
            prev_writedata = writedata;
        end
    end

    always @(posedge clk) begin
        if (!running) begin
            run_cycles <= 0;
        end else if (run_cycles >= timeout_cycles) begin
            $display("Timeout: the CPU did not halt within %0d cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    initial begin
        seed_ret  = $urandom(32'hde20ac0c);
        errors    = 0;
        checks    = 0;
        running   = 1'b0;
        rst_n     = 1'b0;
        load_en   = 1'b0;
        load_addr = 32'd0;
        load_data = 32'd0;
        make_random_program();
        run_program();
        make_slti_program();
        run_program();
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
